// ==== accessDecode.sv ====
/* Access arbitration and decode */

`timescale 1ns/1ps
`include "ctrlRegCfg.svh"

module accessDecode (
  input  logic                       clk,
  input  logic                       srst,
  input  logic                       awPending,
  input  ctrlRegPkg::addrBeat_t      awBeat,
  input  logic                       wPending,
  input  ctrlRegPkg::dataBeat_t      wBeat,
  input  logic                       arPending,
  input  ctrlRegPkg::addrBeat_t      arBeat,
  output logic                       awClear,
  output logic                       wClear,
  output logic                       arClear,
  output ctrlRegPkg::decodedAccess_t decoded,
  output logic                       decodedValid,
  input  logic                       take
);

  import ctrlRegPkg::*;

  logic           validQ;
  decodedAccess_t decodedQ;
  decodedAccess_t nextAccess;
  addrBeat_t      selBeat;
  logic           slotFree;
  logic           writeSel;
  logic           readSel;
  logic           inRange;
  logic           load;

  // The slot can refill in the same cycle execute takes it.
  assign slotFree = !validQ || take;

  // A write needs both AW and W, and wins over a pending read.
  assign writeSel = awPending && wPending;
  assign readSel  = !writeSel && arPending;
  assign selBeat  = writeSel ? awBeat : arBeat;
  assign inRange  = selBeat.addr <= `REG_ADDR_TOP;

  // Classify and truncate to the local address width.
  always_comb
  begin
    nextAccess.addr = selBeat.addr[`REG_ADDR_WIDTH-1:0];
    if (writeSel)
    begin
      nextAccess.kind  = inRange ? RegWrite : BadWrite;
      nextAccess.wData = wBeat.data;
      nextAccess.strb  = wBeat.strb;
    end
    else
    begin
      nextAccess.kind  = inRange ? RegRead : BadRead;
      nextAccess.wData = '0;
      nextAccess.strb  = '0;
    end
  end

  // Consumed input registers are released on load.
  assign awClear = slotFree && writeSel;
  assign wClear  = slotFree && writeSel;
  assign arClear = slotFree && readSel;
  assign load    = awClear || arClear;

  always_ff @(posedge clk)
  begin
    if (srst)
    begin
      validQ <= 1'b0;
    end
    else if (load)
    begin
      validQ <= 1'b1;
    end
    else if (take)
    begin
      validQ <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      decodedQ <= nextAccess;
    end
  end

  assign decoded      = decodedQ;
  assign decodedValid = validQ;

endmodule

// ==== axiInReg.sv ====
/* AXI request channel register */

`timescale 1ns/1ps

module axiInReg #(
  parameter int DataWidth = 16
) (
  input  logic                 clk,
  input  logic                 srst,
  input  logic                 axiValid,
  output logic                 axiReady,
  input  logic [DataWidth-1:0] axiData,
  output logic                 pending,
  input  logic                 clear,
  output logic [DataWidth-1:0] data
);

  // High for the single dead cycle after reset or consume.
  logic                 clearQ;
  logic                 readyQ;
  logic [DataWidth-1:0] dataQ;

  // Empty, then ready, then full until the consumer clears it.
  always_ff @(posedge clk)
  begin
    if (srst || clear)
    begin
      clearQ <= 1'b1;
      readyQ <= 1'b0;
    end
    else if (clearQ)
    begin
      clearQ <= 1'b0;
      readyQ <= 1'b1;
    end
    else if (readyQ && axiValid)
    begin
      readyQ <= 1'b0;
    end
  end

  // Beat is taken only on the handshake.
  always_ff @(posedge clk)
  begin
    if (readyQ && axiValid)
    begin
      dataQ <= axiData;
    end
  end

  assign axiReady = readyQ;
  // Neither dead cycle nor ready means a beat is held.
  assign pending  = !(clearQ || readyQ);
  assign data     = dataQ;

endmodule

// ==== axiOutReg.sv ====
/* AXI response channel register */

`timescale 1ns/1ps

module axiOutReg #(
  parameter int DataWidth = 16
) (
  input  logic                 clk,
  input  logic                 srst,
  input  logic                 push,
  output logic                 blocked,
  input  logic [DataWidth-1:0] din,
  output logic                 axiValid,
  input  logic                 axiReady,
  output logic [DataWidth-1:0] axiData
);

  logic                 validQ;
  logic [DataWidth-1:0] dataQ;
  logic                 load;

  // A push into a full register is not accepted.
  assign load = push && !validQ;

  // Valid holds until the master accepts the beat.
  always_ff @(posedge clk)
  begin
    if (srst)
    begin
      validQ <= 1'b0;
    end
    else if (validQ && axiReady)
    begin
      validQ <= 1'b0;
    end
    else if (load)
    begin
      validQ <= 1'b1;
    end
  end

  // Payload stays stable while valid is up.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      dataQ <= din;
    end
  end

  assign blocked  = validQ;
  assign axiValid = validQ;
  assign axiData  = dataQ;

endmodule

// ==== ctrlRegCfg.svh ====
/* Control register selector widths */

`ifndef CTRL_REG_CFG_SVH
`define CTRL_REG_CFG_SVH

// AXI-Lite slave address width.
`define AXI_ADDR_WIDTH 16

// Local register file address width.
`define REG_ADDR_WIDTH 8

// Highest AXI address served by the local registers.
// Anything above is answered with DECERR.
`define REG_ADDR_TOP 255

// Data path and byte strobe widths.
`define DATA_WIDTH 32
`define STRB_WIDTH 4

`endif

// ==== ctrlRegPkg.sv ====
/* Control register selector types */

`include "ctrlRegCfg.svh"

package ctrlRegPkg;

  // AXI response codes in use.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axiResp_e;

  // Classified access, local or out of range.
  typedef enum logic [1:0] {
    RegWrite = 2'd0,
    RegRead  = 2'd1,
    BadWrite = 2'd2,
    BadRead  = 2'd3
  } accessKind_e;

  // Register handshake sequencer states.
  typedef enum logic [1:0] {
    Idle    = 2'd0,
    Request = 2'd1,
    Wait    = 2'd2
  } execState_e;

  // AW and AR channel beat.
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
  } addrBeat_t;

  // W channel beat.
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic [`STRB_WIDTH-1:0] strb;
  } dataBeat_t;

  // One arbitrated access waiting for execution.
  typedef struct packed {
    accessKind_e                kind;
    logic [`REG_ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0]     wData;
    logic [`STRB_WIDTH-1:0]     strb;
  } decodedAccess_t;

  // Completed access on its way to the B or R channel.
  typedef struct packed {
    accessKind_e            kind;
    axiResp_e               resp;
    logic [`DATA_WIDTH-1:0] rData;
  } accessResult_t;

  // Local register request, driven by the selector.
  typedef struct packed {
    logic                       req;
    logic                       writeEn;
    logic [`REG_ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0]     wData;
    logic [`STRB_WIDTH-1:0]     strb;
  } regBus_t;

endpackage

// ==== ctrlRegSel.sv ====
/* AXI-Lite control register selector */

`timescale 1ns/1ps
`include "ctrlRegCfg.svh"

module ctrlRegSel (
  input  logic                       clk,
  input  logic                       srst,
  input  logic                       awValid,
  output logic                       awReady,
  input  logic [`AXI_ADDR_WIDTH-1:0] awAddr,
  input  logic                       wValid,
  output logic                       wReady,
  input  ctrlRegPkg::dataBeat_t      wData,
  output logic                       bValid,
  input  logic                       bReady,
  output ctrlRegPkg::axiResp_e       bResp,
  input  logic                       arValid,
  output logic                       arReady,
  input  logic [`AXI_ADDR_WIDTH-1:0] arAddr,
  output logic                       rValid,
  input  logic                       rReady,
  output logic [`DATA_WIDTH-1:0]     rData,
  output ctrlRegPkg::axiResp_e       rResp,
  output ctrlRegPkg::regBus_t        regBus,
  input  logic                       regAck,
  input  logic [`DATA_WIDTH-1:0]     regRData
);

  import ctrlRegPkg::*;

  localparam int AddrBeatWidth = $bits(addrBeat_t);
  localparam int DataBeatWidth = $bits(dataBeat_t);

  logic           awPending;
  logic           awClear;
  addrBeat_t      awBeat;
  logic           wPending;
  logic           wClear;
  dataBeat_t      wBeat;
  logic           arPending;
  logic           arClear;
  addrBeat_t      arBeat;
  decodedAccess_t decoded;
  logic           decodedValid;
  logic           take;
  accessResult_t  result;
  logic           resultPush;
  logic           bBlocked;
  logic           rBlocked;

  // Request channel capture, one per AXI channel.
  axiInReg #(.DataWidth(AddrBeatWidth)) awReg (
    .clk(clk), .srst(srst), .axiValid(awValid), .axiReady(awReady),
    .axiData(awAddr), .pending(awPending), .clear(awClear), .data(awBeat)
  );

  axiInReg #(.DataWidth(DataBeatWidth)) wReg (
    .clk(clk), .srst(srst), .axiValid(wValid), .axiReady(wReady),
    .axiData(wData), .pending(wPending), .clear(wClear), .data(wBeat)
  );

  axiInReg #(.DataWidth(AddrBeatWidth)) arReg (
    .clk(clk), .srst(srst), .axiValid(arValid), .axiReady(arReady),
    .axiData(arAddr), .pending(arPending), .clear(arClear), .data(arBeat)
  );

  // Decode, execute, result.
  accessDecode decode (
    .clk(clk), .srst(srst),
    .awPending(awPending), .awBeat(awBeat),
    .wPending(wPending), .wBeat(wBeat),
    .arPending(arPending), .arBeat(arBeat),
    .awClear(awClear), .wClear(wClear), .arClear(arClear),
    .decoded(decoded), .decodedValid(decodedValid), .take(take)
  );

  regAccessExec exec (
    .clk(clk), .srst(srst),
    .decoded(decoded), .decodedValid(decodedValid), .take(take),
    .bBlocked(bBlocked), .rBlocked(rBlocked),
    .regBus(regBus), .regAck(regAck), .regRData(regRData),
    .result(result), .resultPush(resultPush)
  );

  respBuild resp (
    .clk(clk), .srst(srst),
    .result(result), .resultPush(resultPush),
    .bBlocked(bBlocked), .rBlocked(rBlocked),
    .bValid(bValid), .bResp(bResp), .bReady(bReady),
    .rValid(rValid), .rResp(rResp), .rData(rData), .rReady(rReady)
  );

endmodule

// ==== ctrlRegSelTb.sv ====
/* Control register selector testbench */

`timescale 1ns/1ps
`include "ctrlRegCfg.svh"

module ctrlRegSelTb;

  import ctrlRegPkg::*;

  localparam int          ClkPeriod  = 10;
  localparam int          NumTests   = 5;
  localparam int          TestCycles = 200;
  localparam logic [31:0] Seed       = 32'h00066b6b;
  // Model acknowledge delay is 0 to AckSpread-1 extra cycles.
  localparam int          AckSpread  = 4;

  logic                       clk;
  logic                       srst;
  logic                       awValid;
  logic                       awReady;
  logic [`AXI_ADDR_WIDTH-1:0] awAddr;
  logic                       wValid;
  logic                       wReady;
  dataBeat_t                  wData;
  logic                       bValid;
  logic                       bReady;
  axiResp_e                   bResp;
  logic                       arValid;
  logic                       arReady;
  logic [`AXI_ADDR_WIDTH-1:0] arAddr;
  logic                       rValid;
  logic                       rReady;
  logic [`DATA_WIDTH-1:0]     rData;
  axiResp_e                   rResp;
  regBus_t                    regBus;
  logic                       regAck;
  logic [`DATA_WIDTH-1:0]     regRData;

  // Register file model and its request log.
  logic [`DATA_WIDTH-1:0]     regMem [0:255];
  logic [`REG_ADDR_WIDTH-1:0] reqAddrLog[$];
  logic                       reqWriteLog[$];
  logic [31:0]                rngState;
  int                         errorCount;
  int                         passCount;
  int                         failCount;

  ctrlRegSel DUT (
    .clk(clk), .srst(srst),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .bValid(bValid), .bReady(bReady), .bResp(bResp),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
    .regBus(regBus), .regAck(regAck), .regRData(regRData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Xorshift generator for the acknowledge delay.
  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // Byte lanes with a strobe take the new data.
  function automatic logic [`DATA_WIDTH-1:0] mergeStrobes(
    input logic [`DATA_WIDTH-1:0] oldWord,
    input logic [`DATA_WIDTH-1:0] newWord,
    input logic [`STRB_WIDTH-1:0] strb
  );
    logic [`DATA_WIDTH-1:0] merged;
    merged = oldWord;
    for (int i = 0; i < `STRB_WIDTH; i++)
    begin
      if (strb[i])
      begin
        merged[i*8 +: 8] = newWord[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  // Register file model. Acks a request after a random delay.
  initial
  begin
    int delay;
    forever
    begin
      @(posedge clk);
      if (!srst && regBus.req)
      begin
        reqAddrLog.push_back(regBus.addr);
        reqWriteLog.push_back(regBus.writeEn);
        delay = nextRand() % AckSpread;
        repeat (delay) @(posedge clk);
        if (regBus.writeEn)
        begin
          regMem[regBus.addr] = mergeStrobes(regMem[regBus.addr], regBus.wData, regBus.strb);
        end
        else
        begin
          regRData <= regMem[regBus.addr];
        end
        regAck <= 1'b1;
        @(posedge clk);
        regAck <= 1'b0;
      end
    end
  end

  task automatic checkResp(input string testName, input axiResp_e expected,
                           input axiResp_e actual);
    if (expected !== actual)
    begin
      $display("error: %s expected %s actual %s", testName, expected.name(), actual.name());
      errorCount++;
    end
  endtask

  task automatic checkData(input string testName, input logic [`DATA_WIDTH-1:0] expected,
                           input logic [`DATA_WIDTH-1:0] actual);
    if (expected !== actual)
    begin
      $display("error: %s expected %h actual %h", testName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic reportFault(input string testName, input string what);
    $display("%s failed: %s", testName, what);
    errorCount++;
  endtask

  task automatic finishTest(input string testName, input int errorsBefore);
    if (errorCount == errorsBefore)
    begin
      $display("test %s passed", testName);
      passCount++;
    end
    else
    begin
      $display("test %s failed", testName);
      failCount++;
    end
  endtask

  // Present AW with W and/or AR in one cycle, drop each valid on its handshake.
  task automatic issueAccess(input logic doWrite, input logic doRead,
                             input logic [`AXI_ADDR_WIDTH-1:0] wAddr,
                             input logic [`DATA_WIDTH-1:0] wWord,
                             input logic [`STRB_WIDTH-1:0] wStrb,
                             input logic [`AXI_ADDR_WIDTH-1:0] rAddr);
    logic awDone;
    logic wDone;
    logic arDone;
    awDone = !doWrite;
    wDone  = !doWrite;
    arDone = !doRead;
    @(posedge clk);
    if (doWrite)
    begin
      awValid    <= 1'b1;
      awAddr     <= wAddr;
      wValid     <= 1'b1;
      wData.data <= wWord;
      wData.strb <= wStrb;
    end
    if (doRead)
    begin
      arValid <= 1'b1;
      arAddr  <= rAddr;
    end
    while (!(awDone && wDone && arDone))
    begin
      @(posedge clk);
      if (awValid && awReady)
      begin
        awDone = 1'b1;
        awValid <= 1'b0;
      end
      if (wValid && wReady)
      begin
        wDone = 1'b1;
        wValid <= 1'b0;
      end
      if (arValid && arReady)
      begin
        arDone = 1'b1;
        arValid <= 1'b0;
      end
    end
  endtask

  task automatic waitWriteResp(output axiResp_e resp);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (bValid && bReady)
      begin
        resp = bResp;
        done = 1'b1;
      end
    end
  endtask

  task automatic waitReadResp(output axiResp_e resp, output logic [`DATA_WIDTH-1:0] data);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (rValid && rReady)
      begin
        resp = rResp;
        data = rData;
        done = 1'b1;
      end
    end
  endtask

  // Outputs quiet after reset, readies up shortly after.
  task automatic testResetState();
    int errorsBefore;
    int waited;
    errorsBefore = errorCount;
    if (bValid !== 1'b0 || rValid !== 1'b0 || regBus.req !== 1'b0)
    begin
      reportFault("resetState", "a valid or the register request is not low after reset");
    end
    waited = 0;
    while (!(awReady && wReady && arReady) && waited < 4)
    begin
      @(posedge clk);
      waited++;
    end
    if (!(awReady && wReady && arReady))
    begin
      reportFault("resetState", "the channel readies did not rise after reset");
    end
    finishTest("resetState", errorsBefore);
  endtask

  // Full and partial strobe writes, each read back.
  task automatic testLocalAccess();
    int                     errorsBefore;
    axiResp_e               resp;
    logic [`DATA_WIDTH-1:0] data;
    logic [`DATA_WIDTH-1:0] expected;
    errorsBefore = errorCount;
    expected = mergeStrobes(regMem[8'h10], 32'h12345678, 4'b1111);
    issueAccess(1'b1, 1'b0, 16'h0010, 32'h12345678, 4'b1111, '0);
    waitWriteResp(resp);
    checkResp("localAccess", OKAY, resp);
    issueAccess(1'b0, 1'b1, '0, '0, '0, 16'h0010);
    waitReadResp(resp, data);
    checkResp("localAccess", OKAY, resp);
    checkData("localAccess", expected, data);
    // Partial write touches only bytes 0 and 2.
    expected = mergeStrobes(expected, 32'hAABBCCDD, 4'b0101);
    issueAccess(1'b1, 1'b0, 16'h0010, 32'hAABBCCDD, 4'b0101, '0);
    waitWriteResp(resp);
    checkResp("localAccess", OKAY, resp);
    issueAccess(1'b0, 1'b1, '0, '0, '0, 16'h0010);
    waitReadResp(resp, data);
    checkResp("localAccess", OKAY, resp);
    checkData("localAccess", expected, data);
    finishTest("localAccess", errorsBefore);
  endtask

  // Addresses above the local top are refused.
  task automatic testOutOfRange();
    int                     errorsBefore;
    axiResp_e               resp;
    logic [`DATA_WIDTH-1:0] data;
    errorsBefore = errorCount;
    reqAddrLog.delete();
    reqWriteLog.delete();
    issueAccess(1'b1, 1'b0, 16'h0100, 32'hDEADBEEF, 4'b1111, '0);
    waitWriteResp(resp);
    checkResp("outOfRange", DECERR, resp);
    issueAccess(1'b0, 1'b1, '0, '0, '0, 16'hFF00);
    waitReadResp(resp, data);
    checkResp("outOfRange", DECERR, resp);
    checkData("outOfRange", '0, data);
    if (reqAddrLog.size() != 0)
    begin
      reportFault("outOfRange", "a register request was raised for an out-of-range address");
    end
    finishTest("outOfRange", errorsBefore);
  endtask

  // Write and read in the same cycle, the write goes first.
  task automatic testWritePriority();
    int                     errorsBefore;
    axiResp_e               wResp;
    axiResp_e               rRespSeen;
    logic [`DATA_WIDTH-1:0] data;
    logic [`DATA_WIDTH-1:0] expected;
    logic                   gotB;
    logic                   gotR;
    errorsBefore = errorCount;
    reqAddrLog.delete();
    reqWriteLog.delete();
    expected = mergeStrobes(regMem[8'h40], 32'h0BADF00D, 4'b1111);
    issueAccess(1'b1, 1'b1, 16'h0040, 32'h0BADF00D, 4'b1111, 16'h0040);
    gotB = 1'b0;
    gotR = 1'b0;
    while (!(gotB && gotR))
    begin
      @(posedge clk);
      if (bValid && bReady)
      begin
        wResp = bResp;
        gotB  = 1'b1;
      end
      if (rValid && rReady)
      begin
        rRespSeen = rResp;
        data      = rData;
        gotR      = 1'b1;
      end
    end
    if (reqWriteLog.size() == 0 || reqWriteLog[0] !== 1'b1)
    begin
      reportFault("writePriority", "the first register request was not the write");
    end
    checkResp("writePriority", OKAY, wResp);
    checkResp("writePriority", OKAY, rRespSeen);
    checkData("writePriority", expected, data);
    finishTest("writePriority", errorsBefore);
  endtask

  // B channel stalled, the second write must wait.
  task automatic testBackPressure();
    int                     errorsBefore;
    axiResp_e               resp;
    logic [`DATA_WIDTH-1:0] expectA;
    logic [`DATA_WIDTH-1:0] expectB;
    errorsBefore = errorCount;
    reqAddrLog.delete();
    reqWriteLog.delete();
    expectA = mergeStrobes(regMem[8'h20], 32'h11112222, 4'b1111);
    expectB = mergeStrobes(regMem[8'h21], 32'h33334444, 4'b0011);
    @(posedge clk);
    bReady <= 1'b0;
    issueAccess(1'b1, 1'b0, 16'h0020, 32'h11112222, 4'b1111, '0);
    while (!bValid)
    begin
      @(posedge clk);
    end
    issueAccess(1'b1, 1'b0, 16'h0021, 32'h33334444, 4'b0011, '0);
    repeat (20)
    begin
      @(posedge clk);
      if (!bValid)
      begin
        reportFault("backPressure", "the write response valid dropped while stalled");
      end
      checkResp("backPressure", OKAY, bResp);
    end
    if (reqAddrLog.size() != 1)
    begin
      reportFault("backPressure", "a second write reached the register port while stalled");
    end
    @(posedge clk);
    bReady <= 1'b1;
    waitWriteResp(resp);
    checkResp("backPressure", OKAY, resp);
    waitWriteResp(resp);
    checkResp("backPressure", OKAY, resp);
    if (reqAddrLog.size() != 2 || reqAddrLog[0] !== 8'h20 || reqAddrLog[1] !== 8'h21)
    begin
      reportFault("backPressure", "the writes did not reach the register port in order");
    end
    checkData("backPressure", expectA, regMem[8'h20]);
    checkData("backPressure", expectB, regMem[8'h21]);
    finishTest("backPressure", errorsBefore);
  endtask

  // Watchdog, sized from the number of tests.
  initial
  begin
    #(NumTests * TestCycles * ClkPeriod);
    $display("timeout: the run did not finish within %0d cycles", NumTests * TestCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    clk        = 1'b0;
    srst       = 1'b1;
    awValid    = 1'b0;
    awAddr     = '0;
    wValid     = 1'b0;
    wData      = '0;
    bReady     = 1'b1;
    arValid    = 1'b0;
    arAddr     = '0;
    rReady     = 1'b1;
    regAck     = 1'b0;
    regRData   = '0;
    rngState   = Seed;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    // Fill pattern built from the full word address.
    for (int i = 0; i < 256; i++)
    begin
      regMem[i] = {8'hC3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5A};
    end
    repeat (8) @(posedge clk);
    srst <= 1'b0;
    @(posedge clk);
    testResetState();
    testLocalAccess();
    testOutOfRange();
    testWritePriority();
    testBackPressure();
    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== regAccessExec.sv ====
/* Local register handshake sequencer */

`timescale 1ns/1ps
`include "ctrlRegCfg.svh"

module regAccessExec (
  input  logic                       clk,
  input  logic                       srst,
  input  ctrlRegPkg::decodedAccess_t decoded,
  input  logic                       decodedValid,
  output logic                       take,
  input  logic                       bBlocked,
  input  logic                       rBlocked,
  output ctrlRegPkg::regBus_t        regBus,
  input  logic                       regAck,
  input  logic [`DATA_WIDTH-1:0]     regRData,
  output ctrlRegPkg::accessResult_t  result,
  output logic                       resultPush
);

  import ctrlRegPkg::*;

  execState_e                 stateQ;
  logic                       reqQ;
  logic                       writeEnQ;
  logic [`REG_ADDR_WIDTH-1:0] addrQ;
  logic [`DATA_WIDTH-1:0]     wDataQ;
  logic [`STRB_WIDTH-1:0]     strbQ;
  accessResult_t              resultQ;
  logic                       pushQ;
  logic                       isWrite;
  logic                       isLocal;
  logic                       kindBlocked;
  logic                       regDone;

  assign isWrite = (decoded.kind == RegWrite) || (decoded.kind == BadWrite);
  assign isLocal = (decoded.kind == RegWrite) || (decoded.kind == RegRead);

  // Only start when the matching response slot is free.
  assign kindBlocked = isWrite ? bBlocked : rBlocked;
  // A push still in flight has not yet shown up as blocked.
  assign take    = decodedValid && (stateQ == Idle) && !pushQ && !kindBlocked;
  assign regDone = reqQ && regAck;

  always_ff @(posedge clk)
  begin
    if (srst)
    begin
      stateQ <= Idle;
      reqQ   <= 1'b0;
      pushQ  <= 1'b0;
    end
    else
    begin
      pushQ <= 1'b0;
      case (stateQ)
        Idle:
        begin
          // Out of range accesses answer straight away.
          if (take && isLocal)
          begin
            stateQ <= Request;
            reqQ   <= 1'b1;
          end
          else if (take)
          begin
            pushQ <= 1'b1;
          end
        end
        Request:
        begin
          if (regAck)
          begin
            stateQ <= Idle;
            reqQ   <= 1'b0;
            pushQ  <= 1'b1;
          end
          else
          begin
            stateQ <= Wait;
          end
        end
        Wait:
        begin
          if (regAck)
          begin
            stateQ <= Idle;
            reqQ   <= 1'b0;
            pushQ  <= 1'b1;
          end
        end
        default:
        begin
          stateQ <= Idle;
          reqQ   <= 1'b0;
        end
      endcase
    end
  end

  // Request fields and result are fixed at take; read data lands on ack.
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      writeEnQ      <= isWrite;
      addrQ         <= decoded.addr;
      wDataQ        <= decoded.wData;
      strbQ         <= decoded.strb;
      resultQ.kind  <= decoded.kind;
      resultQ.resp  <= isLocal ? OKAY : DECERR;
    end
    else if (regDone && !writeEnQ)
    begin
      resultQ.rData <= regRData;
    end
  end

  assign regBus = '{req: reqQ, writeEn: writeEnQ, addr: addrQ, wData: wDataQ, strb: strbQ};
  assign result     = resultQ;
  assign resultPush = pushQ;

endmodule

// ==== respBuild.sv ====
/* AXI write and read response stage */

`timescale 1ns/1ps
`include "ctrlRegCfg.svh"

module respBuild (
  input  logic                      clk,
  input  logic                      srst,
  input  ctrlRegPkg::accessResult_t result,
  input  logic                      resultPush,
  output logic                      bBlocked,
  output logic                      rBlocked,
  output logic                      bValid,
  output ctrlRegPkg::axiResp_e      bResp,
  input  logic                      bReady,
  output logic                      rValid,
  output ctrlRegPkg::axiResp_e      rResp,
  output logic [`DATA_WIDTH-1:0]    rData,
  input  logic                      rReady
);

  import ctrlRegPkg::*;

  localparam int RespWidth  = $bits(axiResp_e);
  localparam int RBeatWidth = RespWidth + `DATA_WIDTH;

  logic                   isWrite;
  logic                   bPush;
  logic                   rPush;
  logic [`DATA_WIDTH-1:0] rDataIn;
  logic [RespWidth-1:0]   bRespBits;
  logic [RBeatWidth-1:0]  rBeatIn;
  logic [RBeatWidth-1:0]  rBeatOut;

  // Writes go to B, reads to R.
  assign isWrite = (result.kind == RegWrite) || (result.kind == BadWrite);
  assign bPush   = resultPush && isWrite;
  assign rPush   = resultPush && !isWrite;

  // A decode error never returns register data.
  assign rDataIn = (result.resp == DECERR) ? '0 : result.rData;
  assign rBeatIn = {result.resp, rDataIn};

  axiOutReg #(
    .DataWidth(RespWidth)
  ) bReg (
    .clk     (clk),
    .srst    (srst),
    .push    (bPush),
    .blocked (bBlocked),
    .din     (result.resp),
    .axiValid(bValid),
    .axiReady(bReady),
    .axiData (bRespBits)
  );

  axiOutReg #(
    .DataWidth(RBeatWidth)
  ) rReg (
    .clk     (clk),
    .srst    (srst),
    .push    (rPush),
    .blocked (rBlocked),
    .din     (rBeatIn),
    .axiValid(rValid),
    .axiReady(rReady),
    .axiData (rBeatOut)
  );

  assign bResp = axiResp_e'(bRespBits);
  // Response code sits above the data in the R beat.
  assign rResp = axiResp_e'(rBeatOut[RBeatWidth-1 -: RespWidth]);
  assign rData = rBeatOut[`DATA_WIDTH-1:0];

endmodule

// ==== sim.f ====
+incdir+.
ctrlRegPkg.sv
axiInReg.sv
axiOutReg.sv
accessDecode.sv
regAccessExec.sv
respBuild.sv
ctrlRegSel.sv
ctrlRegSelTb.sv
